// ==== dv/cacheAsserts_asserts.sv ====
// Cache protocol assertions
`timescale 1ns/1ps
`default_nettype none

module cacheAsserts #(
	parameter int MemCredits = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic reqValid,
	input wire logic ready,
	input wire logic respValid,
	input wire logic invalValid,
	input wire logic memReqValid,
	input wire logic memCredit
);
	int credits; // tracks the controller's counter from the memory port
	logic outstanding;
	int failures = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= MemCredits;
			outstanding <= 1'b0;
		end else begin
			credits <= credits + int'(memCredit) - int'(memReqValid);
			if (reqValid && ready)
				outstanding <= 1'b1;
			else if (respValid)
				outstanding <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (reset) memReqValid |-> credits > 0)
		else begin
			$error("memory request issued with no credit left");
			failures++;
		end
	assert property (@(posedge clk) disable iff (reset) respValid |-> outstanding)
		else begin
			$error("response without an accepted request");
			failures++;
		end
	assert property (@(posedge clk) disable iff (reset) respValid |=> !respValid)
		else begin
			$error("response held for more than one cycle");
			failures++;
		end
	assert property (@(posedge clk) disable iff (reset) outstanding && !respValid |-> !ready)
		else begin
			$error("ready high while a request is in flight");
			failures++;
		end
	assert property (@(posedge clk) disable iff (reset) !(invalValid && reqValid))
		else begin
			$error("snoop invalidate together with a processor request");
			failures++;
		end

endmodule

bind cacheTop cacheAsserts #(.MemCredits(MemCredits)) asserts (
	.clk, .reset, .reqValid, .ready, .respValid,
	.invalValid, .memReqValid, .memCredit
);

`default_nettype wire

// ==== dv/cacheTb.sv ====
// Cache testbench
`timescale 1ns/1ps
`default_nettype none

module cacheTb import cachePkg::*; ();
	localparam int LineWords = DefLineWords;
	localparam int WordBits = $bits(wordT);
	localparam int LineBits = LineWords * WordBits;
	localparam string TracePath = "dv/cacheTrace.txt";

	logic clk;
	logic reset;
	logic reqValid;
	logic reqWrite;
	addrT reqAddr;
	wordT reqWData;
	logic ready;
	logic respValid;
	wordT respData;
	logic invalValid;
	addrT invalAddr;
	logic memReqValid;
	logic memReqWrite;
	addrT memReqAddr;
	logic [LineBits-1:0] memReqLine;
	logic memCredit;
	logic memRespValid;
	logic [LineBits-1:0] memRespLine;

	string testName[$];
	string testOp[$];
	addrT testAddr[$];
	wordT testWData[$];
	wordT testExpWord[$];
	int testExpRefills[$];
	bit traceLoaded = 1'b0;
	int errorCount = 0;
	int refillCount = 0; // read requests seen by the memory model
	wordT memStore [addrT]; // written-back words, keyed by word address

	cacheTop #(
		.NumSets(DefNumSets),
		.LineWords(LineWords),
		.MemCredits(DefMemCredits)
	) uut (
		.clk, .reset,
		.reqValid, .reqWrite, .reqAddr, .reqWData,
		.ready, .respValid, .respData,
		.invalValid, .invalAddr,
		.memReqValid, .memReqWrite, .memReqAddr, .memReqLine,
		.memCredit, .memRespValid, .memRespLine
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic wordT patternWord(addrT wordAddr);
		return wordAddr ^ 32'hA5A50000; // untouched memory content
	endfunction

	function automatic logic [LineBits-1:0] readLine(addrT lineAddr);
		logic [LineBits-1:0] line;
		addrT wordAddr;
		for (int i = 0; i < LineWords; i++) begin
			wordAddr = (lineAddr >> ByteOffsetBits) + addrT'(i);
			if (memStore.exists(wordAddr))
				line[i*WordBits +: WordBits] = memStore[wordAddr];
			else
				line[i*WordBits +: WordBits] = patternWord(wordAddr);
		end
		return line;
	endfunction

	function automatic void storeLine(addrT lineAddr, logic [LineBits-1:0] line);
		for (int i = 0; i < LineWords; i++)
			memStore[(lineAddr >> ByteOffsetBits) + addrT'(i)] = line[i*WordBits +: WordBits];
	endfunction

	task automatic loadTrace();
		int fd;
		int fields;
		string lineStr;
		string name;
		string op;
		addrT addr;
		wordT wdata;
		wordT expWord;
		int expRefills;
		fd = $fopen(TracePath, "r");
		if (fd == 0) begin
			$display("could not open the trace file %s", TracePath);
			errorCount++;
			return;
		end
		while ($fgets(lineStr, fd) != 0) begin
			if (lineStr.len() < 2 || lineStr.substr(0, 0) == "#")
				continue;
			fields = $sscanf(lineStr, "%s %s %h %h %h %d",
				name, op, addr, wdata, expWord, expRefills);
			if (fields != 6) begin
				$display("trace line could not be parsed: %s", lineStr);
				errorCount++;
				continue;
			end
			testName.push_back(name);
			testOp.push_back(op);
			testAddr.push_back(addr);
			testWData.push_back(wdata);
			testExpWord.push_back(expWord);
			testExpRefills.push_back(expRefills);
		end
		$fclose(fd);
	endtask

	task automatic compareWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			$display("ERROR %s read data expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic compareCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s refill count expected %0d actual %0d", name, expected, actual);
			errorCount++;
		end
	endtask

	// called on an edge where ready is high
	task automatic issueRequest(input logic write, input addrT addr, input wordT data,
			output wordT rdata);
		reqValid <= 1'b1;
		reqWrite <= write;
		reqAddr <= addr;
		reqWData <= data;
		do @(posedge clk); while (!ready); // accepted on this edge
		reqValid <= 1'b0;
		do @(posedge clk); while (!respValid);
		rdata = respData;
	endtask

	task automatic snoopInvalidate(input addrT addr);
		invalValid <= 1'b1;
		invalAddr <= addr;
		@(posedge clk);
		invalValid <= 1'b0;
	endtask

	initial begin : memoryModel
		int cycleCount;
		int respAt;
		bit respPending;
		addrT respAddr;
		int creditDue[$];
		void'($urandom(72735));
		memCredit <= 1'b0;
		memRespValid <= 1'b0;
		memRespLine <= '0;
		cycleCount = 0;
		respAt = 0;
		respPending = 1'b0;
		respAddr = '0;
		forever begin
			@(posedge clk);
			cycleCount++;
			memCredit <= 1'b0;
			memRespValid <= 1'b0;
			if (!reset && memReqValid) begin
				if (memReqWrite) begin
					storeLine(memReqAddr, memReqLine);
				end else begin
					refillCount++;
					respPending = 1'b1;
					respAddr = memReqAddr;
					respAt = cycleCount + int'($urandom_range(6, 1));
				end
				creditDue.push_back(cycleCount + int'($urandom_range(6, 1)));
			end
			// at most one credit back per cycle, the rest wait longer
			for (int i = 0; i < creditDue.size(); i++) begin
				if (creditDue[i] <= cycleCount) begin
					memCredit <= 1'b1;
					creditDue.delete(i);
					break;
				end
			end
			if (respPending && cycleCount >= respAt) begin
				memRespValid <= 1'b1;
				memRespLine <= readLine(respAddr);
				respPending = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (traceLoaded);
		repeat ((testName.size() + 1) * 200) @(posedge clk);
		$display("timeout: the cache stopped answering before the trace finished");
		$display("Test failures found");
		$finish;
	end

	initial begin : mainSequence
		int passCount;
		int failCount;
		int errorsBefore;
		wordT readData;
		passCount = 0;
		failCount = 0;
		reset <= 1'b1;
		reqValid <= 1'b0;
		reqWrite <= 1'b0;
		reqAddr <= '0;
		reqWData <= '0;
		invalValid <= 1'b0;
		invalAddr <= '0;
		loadTrace();
		traceLoaded = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int t = 0; t < testName.size(); t++) begin
			errorsBefore = errorCount;
			if (testOp[t] == "read") begin
				issueRequest(1'b0, testAddr[t], '0, readData);
				compareWord(testName[t], testExpWord[t], readData);
				compareCount(testName[t], testExpRefills[t], refillCount);
			end else if (testOp[t] == "write") begin
				issueRequest(1'b1, testAddr[t], testWData[t], readData);
				compareCount(testName[t], testExpRefills[t], refillCount);
			end else if (testOp[t] == "invalidate") begin
				snoopInvalidate(testAddr[t]);
				compareCount(testName[t], testExpRefills[t], refillCount);
			end else begin
				$display("test %s has an unknown operation %s", testName[t], testOp[t]);
				errorCount++;
			end
			if (errorCount == errorsBefore) begin
				passCount++;
				$display("test %s ok", testName[t]);
			end else begin
				failCount++;
				$display("test %s failed", testName[t]);
			end
		end
		if (uut.asserts.failures != 0) begin
			$display("%0d protocol assertions failed during the run", uut.asserts.failures);
			errorCount += uut.asserts.failures;
		end
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/cacheTrace.txt ====
# name op address wdata expected_read expected_refills
# hex address and data; expected_read counts for reads only, refills is the running total
rdCold read 00000040 00000000 a5a50010 1
rdColdNext read 0000004c 00000000 a5a50013 1
wrHit write 00000044 11223344 00000000 1
rdAfterWr read 00000044 00000000 11223344 1
wrMiss write 00000080 cafef00d 00000000 2
rdWrMiss read 00000080 00000000 cafef00d 2
rdWrMissNext read 00000084 00000000 a5a50021 2
lruReadA read 00001030 00000000 a5a5040c 3
lruReadB read 00002030 00000000 a5a5080c 4
lruTouchA read 00001030 00000000 a5a5040c 4
lruReadC read 00003030 00000000 a5a50c0c 5
lruKeepA read 00001030 00000000 a5a5040c 5
lruLostB read 00002030 00000000 a5a5080c 6
wbWriteD write 00001054 deadbeef 00000000 7
wbReadE read 00002050 00000000 a5a50814 8
wbEvictD read 00003050 00000000 a5a50c14 9
wbReloadD read 00001054 00000000 deadbeef 10
wbNeighborD read 00001050 00000000 a5a50414 10
invWrite write 00004070 55aa55aa 00000000 11
invHit read 00004070 00000000 55aa55aa 11
invDrop invalidate 00004070 00000000 00000000 11
invReread read 00004070 00000000 a5a5101c 12
bpWrite1 write 00001090 0000aaa1 00000000 13
bpWrite2 write 00002090 0000aaa2 00000000 14
bpWrite3 write 00003090 0000aaa3 00000000 15
bpWrite4 write 00004090 0000aaa4 00000000 16
bpRead1 read 00001090 00000000 0000aaa1 17
bpRead2 read 00002090 00000000 0000aaa2 18
bpRead3 read 00003090 00000000 0000aaa3 19
bpRead4 read 00004090 00000000 0000aaa4 20

// ==== logic/cachePkg.sv ====
// Cache shared definitions
`default_nettype none

package cachePkg;

	typedef logic [31:0] addrT; // processor byte address
	typedef logic [31:0] wordT;
	typedef logic wayT; // way 0 or way 1

	// missController sequencing
	typedef enum logic [2:0] {
		idle,
		lookup,
		writeBack,
		refillReq,
		refillWait
	} ctrlStateT;

	localparam int ByteOffsetBits = 2; // byte select inside a word

	// geometry and credit defaults for the top level
	localparam int DefNumSets = 16;
	localparam int DefLineWords = 4;
	localparam int DefMemCredits = 2;

endpackage

`default_nettype wire

// ==== logic/cacheTop.sv ====
// Two-way write-back cache
`timescale 1ns/1ps
`default_nettype none

module cacheTop import cachePkg::*; #(
	parameter int NumSets = DefNumSets,
	parameter int LineWords = DefLineWords,
	parameter int MemCredits = DefMemCredits,
	localparam int LineBits = LineWords * $bits(wordT)
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic reqValid,
	input wire logic reqWrite,
	input wire addrT reqAddr,
	input wire wordT reqWData,
	output logic ready,
	output logic respValid,
	output wordT respData,
	input wire logic invalValid,
	input wire addrT invalAddr,
	output logic memReqValid,
	output logic memReqWrite,
	output addrT memReqAddr,
	output logic [LineBits-1:0] memReqLine,
	input wire logic memCredit,
	input wire logic memRespValid,
	input wire logic [LineBits-1:0] memRespLine
);
	localparam int TagBits = $bits(addrT) - $clog2(NumSets) - $clog2(LineWords) - ByteOffsetBits;

	addrT lookupAddr;
	logic touch, markDirty, fill, clearDirty;
	wayT touchWay, fillWay, way;
	logic hit, victimDirty;
	wayT hitWay, victimWay;
	logic [TagBits-1:0] victimTag;
	logic wordWrite, lineFill;
	wordT wData, readWord;
	logic [LineBits-1:0] fillLine, victimLine;

	missController #(
		.NumSets(NumSets),
		.LineWords(LineWords),
		.MemCredits(MemCredits)
	) ctrl (
		.clk, .reset,
		.reqValid, .reqWrite, .reqAddr, .reqWData,
		.hit, .hitWay, .victimWay, .victimDirty, .victimTag,
		.readWord, .victimLine,
		.memCredit, .memRespValid, .memRespLine,
		.ready, .respValid, .respData,
		.lookupAddr, .touch, .touchWay, .markDirty,
		.fill, .fillWay, .clearDirty,
		.wordWrite, .wData, .lineFill, .fillLine, .way,
		.memReqValid, .memReqWrite, .memReqAddr, .memReqLine
	);

	tagStore #(.NumSets(NumSets), .LineWords(LineWords)) tags (
		.clk, .reset, .lookupAddr, .invalValid, .invalAddr,
		.touch, .touchWay, .markDirty, .fill, .fillWay, .clearDirty,
		.hit, .hitWay, .victimWay, .victimDirty, .victimTag
	);

	dataStore #(.NumSets(NumSets), .LineWords(LineWords)) data (
		.clk, .addr(lookupAddr), .way, .wordWrite, .wData,
		.lineFill, .fillLine, .readWord, .victimLine
	);

endmodule

`default_nettype wire

// ==== logic/dataStore.sv ====
// Cache line storage
`timescale 1ns/1ps
`default_nettype none

module dataStore import cachePkg::*; #(
	parameter int NumSets = 16,
	parameter int LineWords = 4
) (
	input wire logic clk,
	input wire addrT addr,
	input wire wayT way,
	input wire logic wordWrite,
	input wire wordT wData,
	input wire logic lineFill,
	input wire logic [LineWords*$bits(wordT)-1:0] fillLine,
	output wordT readWord,
	output logic [LineWords*$bits(wordT)-1:0] victimLine
);
	localparam int IndexBits = $clog2(NumSets);
	localparam int OffsetBits = $clog2(LineWords);
	localparam int WordBits = $bits(wordT);

	wordT mem [2][NumSets][LineWords];

	logic [IndexBits-1:0] index;
	logic [OffsetBits-1:0] offset;

	assign offset = addr[ByteOffsetBits +: OffsetBits];
	assign index = addr[ByteOffsetBits + OffsetBits +: IndexBits];

	assign readWord = mem[way][index][offset];

	always_comb begin
		for (int i = 0; i < LineWords; i++)
			victimLine[i*WordBits +: WordBits] = mem[way][index][i]; // word 0 in the low bits
	end

	always_ff @(posedge clk) begin
		if (lineFill) begin
			for (int i = 0; i < LineWords; i++)
				mem[way][index][i] <= fillLine[i*WordBits +: WordBits];
		end else if (wordWrite) begin
			mem[way][index][offset] <= wData;
		end
	end

endmodule

`default_nettype wire

// ==== logic/missController.sv ====
// Cache request and miss sequencer
`timescale 1ns/1ps
`default_nettype none

module missController import cachePkg::*; #(
	parameter int NumSets = 16,
	parameter int LineWords = 4,
	parameter int MemCredits = 2,
	localparam int IndexBits = $clog2(NumSets),
	localparam int OffsetBits = $clog2(LineWords),
	localparam int TagBits = $bits(addrT) - IndexBits - OffsetBits - ByteOffsetBits,
	localparam int LineBits = LineWords * $bits(wordT)
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic reqValid,
	input wire logic reqWrite,
	input wire addrT reqAddr,
	input wire wordT reqWData,
	input wire logic hit,
	input wire wayT hitWay,
	input wire wayT victimWay,
	input wire logic victimDirty,
	input wire logic [TagBits-1:0] victimTag,
	input wire wordT readWord,
	input wire logic [LineBits-1:0] victimLine,
	input wire logic memCredit,
	input wire logic memRespValid,
	input wire logic [LineBits-1:0] memRespLine,
	output logic ready,
	output logic respValid,
	output wordT respData,
	output addrT lookupAddr,
	output logic touch,
	output wayT touchWay,
	output logic markDirty,
	output logic fill,
	output wayT fillWay,
	output logic clearDirty,
	output logic wordWrite,
	output wordT wData,
	output logic lineFill,
	output logic [LineBits-1:0] fillLine,
	output wayT way,
	output logic memReqValid,
	output logic memReqWrite,
	output addrT memReqAddr,
	output logic [LineBits-1:0] memReqLine
);
	localparam int IndexLo = ByteOffsetBits + OffsetBits;
	localparam int CreditBits = $clog2(MemCredits + 1);

	ctrlStateT state;
	logic [CreditBits-1:0] credits;
	logic haveCredit;
	logic reqWriteReg;
	addrT addrReg;
	wordT wDataReg;
	wayT victimReg;
	addrT wbAddr, refillAddr;

	assign haveCredit = credits != '0;
	assign ready = state == idle;

	assign lookupAddr = addrReg;
	assign wData = wDataReg;
	assign way = (state == lookup) ? hitWay : victimReg;

	// hit path, also taken by the retry after refill
	assign touch = state == lookup && hit;
	assign touchWay = hitWay;
	assign markDirty = touch && reqWriteReg;
	assign wordWrite = markDirty;

	assign fill = state == refillWait && memRespValid;
	assign fillWay = victimReg;
	assign lineFill = fill;
	assign fillLine = memRespLine;
	assign clearDirty = state == writeBack && haveCredit; // write-back leaves this cycle

	assign wbAddr = {victimTag, addrReg[IndexLo +: IndexBits], {IndexLo{1'b0}}};
	assign refillAddr = {addrReg[$bits(addrT)-1:IndexLo], {IndexLo{1'b0}}};

	assign memReqValid = (state == writeBack || state == refillReq) && haveCredit;
	assign memReqWrite = state == writeBack;
	assign memReqAddr = memReqWrite ? wbAddr : refillAddr;
	assign memReqLine = victimLine;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			respValid <= 1'b0;
			credits <= CreditBits'(MemCredits);
		end else begin
			respValid <= 1'b0;
			credits <= credits + CreditBits'(memCredit) - CreditBits'(memReqValid);
			case (state)
				idle: begin
					if (reqValid)
						state <= lookup;
				end
				lookup: begin
					if (hit) begin
						respValid <= 1'b1;
						state <= idle;
					end else if (victimDirty) begin
						state <= writeBack;
					end else begin
						state <= refillReq;
					end
				end
				writeBack: if (haveCredit) state <= refillReq;
				refillReq: if (haveCredit) state <= refillWait;
				refillWait: if (memRespValid) state <= lookup; // retry as a hit
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready && reqValid) begin
			addrReg <= reqAddr;
			reqWriteReg <= reqWrite;
			wDataReg <= reqWData;
		end
		if (touch)
			respData <= readWord;
		if (state == lookup && !hit)
			victimReg <= victimWay;
	end

endmodule

`default_nettype wire

// ==== logic/tagStore.sv ====
// Cache tag and state arrays
`timescale 1ns/1ps
`default_nettype none

module tagStore import cachePkg::*; #(
	parameter int NumSets = 16,
	parameter int LineWords = 4,
	localparam int IndexBits = $clog2(NumSets),
	localparam int OffsetBits = $clog2(LineWords),
	localparam int TagBits = $bits(addrT) - IndexBits - OffsetBits - ByteOffsetBits
) (
	input wire logic clk,
	input wire logic reset,
	input wire addrT lookupAddr,
	input wire logic invalValid,
	input wire addrT invalAddr,
	input wire logic touch,
	input wire wayT touchWay,
	input wire logic markDirty,
	input wire logic fill,
	input wire wayT fillWay,
	input wire logic clearDirty,
	output logic hit,
	output wayT hitWay,
	output wayT victimWay,
	output logic victimDirty,
	output logic [TagBits-1:0] victimTag
);
	localparam int IndexLo = ByteOffsetBits + OffsetBits;

	logic [TagBits-1:0] tagArr [2][NumSets];
	logic [NumSets-1:0] validArr [2];
	logic [NumSets-1:0] dirtyArr [2];
	logic [NumSets-1:0] lruArr; // holds the least recently used way

	logic [IndexBits-1:0] index, invalIndex;
	logic [TagBits-1:0] tag, invalTag;
	logic hit0, hit1;

	assign index = lookupAddr[IndexLo +: IndexBits];
	assign tag = lookupAddr[$bits(addrT)-1 -: TagBits];
	assign invalIndex = invalAddr[IndexLo +: IndexBits];
	assign invalTag = invalAddr[$bits(addrT)-1 -: TagBits];

	assign hit0 = validArr[0][index] && (tagArr[0][index] == tag);
	assign hit1 = validArr[1][index] && (tagArr[1][index] == tag);
	assign hit = hit0 | hit1;
	assign hitWay = hit1;

	assign victimWay = lruArr[index];
	assign victimDirty = validArr[victimWay][index] && dirtyArr[victimWay][index];
	assign victimTag = tagArr[victimWay][index];

	always_ff @(posedge clk) begin
		if (reset) begin
			validArr[0] <= '0;
			validArr[1] <= '0;
			dirtyArr[0] <= '0;
			dirtyArr[1] <= '0;
			lruArr <= '0;
		end else begin
			// snoop hit drops the line, dirty or not
			for (int w = 0; w < 2; w++) begin
				if (invalValid && validArr[w][invalIndex] && tagArr[w][invalIndex] == invalTag)
					validArr[w][invalIndex] <= 1'b0;
			end
			if (touch)
				lruArr[index] <= ~touchWay;
			if (markDirty)
				dirtyArr[touchWay][index] <= 1'b1;
			if (clearDirty)
				dirtyArr[fillWay][index] <= 1'b0; // victim now in memory
			if (fill) begin
				validArr[fillWay][index] <= 1'b1;
				dirtyArr[fillWay][index] <= 1'b0;
				lruArr[index] <= ~fillWay;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill)
			tagArr[fillWay][index] <= tag;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module cacheTb \
	--Mdir obj_dir -o cacheSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cacheSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sources.f ====
logic/cachePkg.sv
logic/tagStore.sv
logic/dataStore.sv
logic/missController.sv
logic/cacheTop.sv
dv/cacheAsserts_asserts.sv
dv/cacheTb.sv
